//--- audio_recorder_top.f
src/rec_ctrl_pkg.sv
src/rec_sample_pkg.sv
src/key_debounce.sv
src/rec_controller.sv
src/sample_ram.sv
src/play_dsp.sv
src/rec_display.sv
src/audio_recorder_top.sv
verif/audio_recorder_assertions.sv
verif/audio_recorder_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the audio recorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module audio_recorder_tb \
        -f audio_recorder_top.f; then
    echo "verilator build failed"
    exit 1
fi

# let the run go on past assertion errors so the testbench prints its verdict
out=$(./obj_dir/Vaudio_recorder_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

//--- src/audio_recorder_top.sv
`timescale 1ns/1ns

module audio_recorder_top #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic [2:0]               i_key,
    input  rec_ctrl_pkg::play_cfg_t  i_cfg,
    input  logic                     i_sample_stb,
    input  rec_sample_pkg::sample_t  i_adc_sample,
    output rec_sample_pkg::sample_t  o_dac_sample,
    output logic                     o_dac_valid,
    output logic [5:0]               o_led_state,
    output logic [7:0][6:0]          o_hex
);
    import rec_ctrl_pkg::*;
    import rec_sample_pkg::*;

    logic [2:0]        press;
    key_cmd_t          cmd;
    rec_state_e        state;
    mem_req_t          rec_req;
    mem_req_t          rd_req;
    mem_req_t          mem_req;
    sample_t           rdata;
    logic [ADDR_W-1:0] end_addr;
    logic [ADDR_W-1:0] play_pos;
    logic              play_done;

    // key 0 record, key 1 play, key 2 stop
    for (genvar gi = 0; gi < 3; gi++) begin : g_deb
        key_debounce #(
            .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
        ) deb (
            .i_clk  (i_clk),
            .i_rst  (i_rst),
            .i_key  (i_key[gi]),
            .o_press(press[gi])
        );
    end

    assign cmd = '{record: press[0], play: press[1], stop: press[2]};

    rec_controller ctrl0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cmd       (cmd),
        .i_sample_stb(i_sample_stb),
        .i_adc_sample(i_adc_sample),
        .i_play_done (play_done),
        .o_state     (state),
        .o_rec_req   (rec_req),
        .o_end_addr  (end_addr)
    );

    // playback owns the memory port only while playing
    assign mem_req = (state == REC_PLAY) ? rd_req : rec_req;

    sample_ram ram0 (
        .i_clk  (i_clk),
        .i_req  (mem_req),
        .o_rdata(rdata)
    );

    play_dsp dsp0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_state     (state),
        .i_cfg       (i_cfg),
        .i_end_addr  (end_addr),
        .i_sample_stb(i_sample_stb),
        .i_rdata     (rdata),
        .o_rd_req    (rd_req),
        .o_dac_sample(o_dac_sample),
        .o_dac_valid (o_dac_valid),
        .o_play_pos  (play_pos),
        .o_play_done (play_done)
    );

    rec_display disp0 (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_state    (state),
        .i_cfg      (i_cfg),
        .i_play_pos (play_pos),
        .i_end_addr (end_addr),
        .o_led_state(o_led_state),
        .o_hex      (o_hex)
    );

endmodule

//--- src/key_debounce.sv
`timescale 1ns/1ns

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_key,
    output logic o_press
);
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic             key_meta;
    logic             key_sync;
    logic             level;
    logic             level_q;
    logic [CNT_W-1:0] cnt;

    // two-flop synchronizer, released key reads high
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
        end else begin
            key_meta <= i_key;
            key_sync <= key_meta;
        end
    end

    // filtered level follows the key only after a steady run
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt     <= '0;
            level   <= 1'b1;
            level_q <= 1'b1;
        end else begin
            level_q <= level;
            if (key_sync == level) begin
                cnt <= '0;
            end else if (cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                level <= key_sync;
                cnt   <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // press is the falling edge of the filtered level
    assign o_press = level_q & ~level;

endmodule

//--- src/play_dsp.sv
`timescale 1ns/1ns

module play_dsp (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  rec_ctrl_pkg::rec_state_e          i_state,
    input  rec_ctrl_pkg::play_cfg_t           i_cfg,
    input  logic [rec_sample_pkg::ADDR_W-1:0] i_end_addr,
    input  logic                              i_sample_stb,
    input  rec_sample_pkg::sample_t           i_rdata,
    output rec_sample_pkg::mem_req_t          o_rd_req,
    output rec_sample_pkg::sample_t           o_dac_sample,
    output logic                              o_dac_valid,
    output logic [rec_sample_pkg::ADDR_W-1:0] o_play_pos,
    output logic                              o_play_done
);
    import rec_ctrl_pkg::*;
    import rec_sample_pkg::*;

    // per-strobe control carried along with the two reads
    typedef struct packed {
        logic       interp;
        logic [1:0] k;
        logic [2:0] j;
        logic       done;
    } tap_t;

    logic                      stb_play;
    logic                      slow;
    logic                      group_end;
    logic                      at_last;
    logic [3:0]                grp_len;
    logic [ADDR_W:0]           step;
    logic [ADDR_W:0]           next_pos;
    logic [ADDR_W-1:0]         rd_addr;
    logic [ADDR_W-1:0]         nbr_addr;
    logic [2:0]                phase;
    tap_t                      tap;
    tap_t                      s1_tap;
    tap_t                      s2_tap;
    logic                      v1;
    logic                      v2;
    logic [ADDR_W-1:0]         s1_nbr;
    sample_t                   s2_cur;
    logic signed [SAMPLE_W:0]   diff;
    logic signed [SAMPLE_W+3:0] prod;
    logic signed [SAMPLE_W+3:0] ofs;

    assign stb_play = i_sample_stb && (i_state == REC_PLAY);
    assign slow     = !i_cfg.fast && (i_cfg.k != 2'd0);

    // slow mode holds each address for 2**k strobes
    assign grp_len   = 4'd1 << i_cfg.k;
    assign group_end = !slow || ({1'b0, phase} >= grp_len - 4'd1);

    assign step     = i_cfg.fast ? ((ADDR_W+1)'(1) << i_cfg.k) : (ADDR_W+1)'(1);
    assign next_pos = {1'b0, rd_addr} + step;

    // neighbour for interpolation, last sample pairs with itself
    assign at_last  = ({1'b0, rd_addr} + 1'b1) >= {1'b0, i_end_addr};
    assign nbr_addr = at_last ? rd_addr : rd_addr + 1'b1;

    assign tap = '{
        interp: i_cfg.interp && slow,
        k:      i_cfg.k,
        j:      slow ? phase : 3'd0,
        done:   group_end && (next_pos >= {1'b0, i_end_addr})
    };

    // play position, restarts whenever the recorder is idle
    always_ff @(posedge i_clk) begin
        if (i_rst || (i_state == REC_IDLE)) begin
            rd_addr <= '0;
            phase   <= '0;
        end else if (stb_play) begin
            if (group_end) begin
                rd_addr <= next_pos[ADDR_W-1:0];
                phase   <= '0;
            end else begin
                phase <= phase + 3'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            v1 <= stb_play;
            v2 <= v1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (stb_play) begin
            s1_tap <= tap;
            s1_nbr <= nbr_addr;
        end
        if (v1) begin
            s2_tap <= s1_tap;
            s2_cur <= i_rdata;
        end
    end

    // strobe cycle reads a, the cycle after reads the neighbour
    assign o_rd_req = '{we: 1'b0, addr: v1 ? s1_nbr : rd_addr, wdata: '0};

    // neighbour data arrives in the output cycle
    assign diff = i_rdata - s2_cur;
    assign prod = diff * $signed({1'b0, s2_tap.j});
    assign ofs  = prod >>> s2_tap.k;

    assign o_dac_sample = s2_tap.interp ? sample_t'(s2_cur + ofs) : s2_cur;
    assign o_dac_valid  = v2 && (i_state == REC_PLAY);
    assign o_play_done  = o_dac_valid && s2_tap.done;
    assign o_play_pos   = rd_addr;

endmodule

//--- src/rec_controller.sv
`timescale 1ns/1ns

module rec_controller (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  rec_ctrl_pkg::key_cmd_t            i_cmd,
    input  logic                              i_sample_stb,
    input  rec_sample_pkg::sample_t           i_adc_sample,
    input  logic                              i_play_done,
    output rec_ctrl_pkg::rec_state_e          o_state,
    output rec_sample_pkg::mem_req_t          o_rec_req,
    output logic [rec_sample_pkg::ADDR_W-1:0] o_end_addr
);
    import rec_ctrl_pkg::*;
    import rec_sample_pkg::*;

    rec_state_e        state;
    rec_state_e        state_nxt;
    logic [ADDR_W-1:0] rec_addr;
    logic [ADDR_W-1:0] end_addr;
    logic              wr_en;
    logic              last_addr;

    // one write per strobe while recording
    assign wr_en     = (state == REC_RECORD) && i_sample_stb;
    assign last_addr = (rec_addr == ADDR_W'(MEM_DEPTH - 1));

    always_comb begin
        state_nxt = state;
        if (i_cmd.stop) begin
            state_nxt = REC_IDLE;
        end else begin
            case (state)
                REC_IDLE: begin
                    if (i_cmd.record) begin
                        state_nxt = REC_RECORD;
                    end else if (i_cmd.play && (end_addr != '0)) begin
                        state_nxt = REC_PLAY;
                    end
                end
                REC_RECORD: begin
                    // full memory ends the take
                    if (wr_en && last_addr) begin
                        state_nxt = REC_IDLE;
                    end else if (i_cmd.record) begin
                        state_nxt = REC_RECORD_PAUSE;
                    end
                end
                REC_RECORD_PAUSE: begin
                    if (i_cmd.record) begin
                        state_nxt = REC_RECORD;
                    end
                end
                REC_PLAY: begin
                    if (i_cmd.play) begin
                        state_nxt = REC_PLAY_PAUSE;
                    end else if (i_play_done) begin
                        state_nxt = REC_IDLE;
                    end
                end
                REC_PLAY_PAUSE: begin
                    if (i_cmd.play) begin
                        state_nxt = REC_PLAY;
                    end
                end
                default: state_nxt = REC_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= REC_IDLE;
            rec_addr <= '0;
            end_addr <= '0;
        end else begin
            state <= state_nxt;
            if ((state == REC_IDLE) && (state_nxt == REC_RECORD)) begin
                // new take overwrites from address 0
                rec_addr <= '0;
                end_addr <= '0;
            end else if (wr_en) begin
                rec_addr <= rec_addr + 1'b1;
                // end address saturates at the top of the 12-bit range
                end_addr <= last_addr ? rec_addr : rec_addr + 1'b1;
            end
        end
    end

    assign o_rec_req = '{we: wr_en, addr: rec_addr, wdata: i_adc_sample};

    assign o_state    = state;
    assign o_end_addr = end_addr;

endmodule

//--- src/rec_ctrl_pkg.sv
package rec_ctrl_pkg;

    // recorder states, the display lights LED n for state n
    typedef enum logic [2:0] {
        REC_IDLE         = 3'd0,
        REC_RECORD       = 3'd1,
        REC_RECORD_PAUSE = 3'd2,
        REC_PLAY         = 3'd3,
        REC_PLAY_PAUSE   = 3'd4
    } rec_state_e;

    // debounced key presses, each a one-cycle pulse
    typedef struct packed {
        logic record;
        logic play;
        logic stop;
    } key_cmd_t;

    // playback setting
    // speed factor is 2**k, fast skips samples, otherwise k > 0 plays slow
    typedef struct packed {
        logic       fast;
        logic       interp;
        logic [1:0] k;
    } play_cfg_t;

endpackage

//--- src/rec_display.sv
`timescale 1ns/1ns

module rec_display (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  rec_ctrl_pkg::rec_state_e          i_state,
    input  rec_ctrl_pkg::play_cfg_t           i_cfg,
    input  logic [rec_sample_pkg::ADDR_W-1:0] i_play_pos,
    input  logic [rec_sample_pkg::ADDR_W-1:0] i_end_addr,
    output logic [5:0]                        o_led_state,
    output logic [7:0][6:0]                   o_hex
);
    // active-low glyphs, bit 0 is segment a
    localparam logic [6:0] SEG_DASH  = 7'b0111111;
    localparam logic [6:0] SEG_I     = 7'b1111011;
    localparam logic [6:0] SEG_BLANK = 7'b1111111;

    function automatic logic [6:0] seg7(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_led_state <= 6'b000001;
            o_hex       <= '1;
        end else begin
            o_led_state <= 6'd1 << i_state;
            // end address, top digit stays 0 for a 12-bit address
            o_hex[0] <= seg7(i_end_addr[3:0]);
            o_hex[1] <= seg7(i_end_addr[7:4]);
            o_hex[2] <= seg7(i_end_addr[11:8]);
            o_hex[3] <= seg7(4'h0);
            o_hex[4] <= seg7(i_play_pos[7:4]);
            o_hex[5] <= seg7(i_play_pos[11:8]);
            o_hex[6] <= seg7(4'd1 << i_cfg.k);
            if (i_cfg.k == 2'd0) begin
                o_hex[7] <= SEG_DASH;
            end else if (i_cfg.fast) begin
                o_hex[7] <= seg7(4'hf);
            end else begin
                o_hex[7] <= i_cfg.interp ? SEG_I : SEG_BLANK;
            end
        end
    end

endmodule

//--- src/rec_sample_pkg.sv
package rec_sample_pkg;

    localparam int SAMPLE_W  = 16;
    localparam int ADDR_W    = 12;
    localparam int MEM_DEPTH = 1 << ADDR_W;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // one access on the sample memory port
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        sample_t           wdata;
    } mem_req_t;

endpackage

//--- src/sample_ram.sv
`timescale 1ns/1ns

module sample_ram (
    input  logic                     i_clk,
    input  rec_sample_pkg::mem_req_t i_req,
    output rec_sample_pkg::sample_t  o_rdata
);
    import rec_sample_pkg::*;

    sample_t mem [MEM_DEPTH];

    // single port, read returns the old word on a write cycle
    always_ff @(posedge i_clk) begin
        if (i_req.we) begin
            mem[i_req.addr] <= i_req.wdata;
        end
        o_rdata <= mem[i_req.addr];
    end

endmodule

//--- verif/audio_recorder_assertions.sv
`timescale 1ns/1ns

module audio_recorder_assertions (
    input logic                     i_clk,
    input logic                     i_rst,
    input logic                     i_sample_stb,
    input logic                     i_dac_valid,
    input logic [2:0]               i_press,
    input logic [5:0]               i_led_state,
    input rec_ctrl_pkg::rec_state_e i_state,
    input rec_sample_pkg::mem_req_t i_mem_req
);
    import rec_ctrl_pkg::*;

    // failures so far, the testbench reads this at the end of the run
    int fail_count = 0;

    led_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot(i_led_state))
    else begin
        $error("state LEDs are not one-hot");
        fail_count++;
    end

    // output only while playing, two cycles after its strobe
    dac_after_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
        i_dac_valid |-> (i_state == REC_PLAY) && $past(i_sample_stb, 2))
    else begin
        $error("DAC valid without a play strobe two cycles earlier");
        fail_count++;
    end

    dac_for_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
        ($past(i_sample_stb, 2) && ($past(i_state, 2) == REC_PLAY) && (i_state == REC_PLAY))
        |-> i_dac_valid)
    else begin
        $error("play strobe gave no DAC sample two cycles later");
        fail_count++;
    end

    write_in_record: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mem_req.we |-> (i_state == REC_RECORD))
    else begin
        $error("sample memory written outside of recording");
        fail_count++;
    end

    press_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_press & $past(i_press)) == 3'b000)
    else begin
        $error("key press pulse longer than one cycle");
        fail_count++;
    end

endmodule

bind audio_recorder_top audio_recorder_assertions asrt0 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_sample_stb(i_sample_stb),
    .i_dac_valid (o_dac_valid),
    .i_press     (press),
    .i_led_state (o_led_state),
    .i_state     (state),
    .i_mem_req   (mem_req)
);

//--- verif/audio_recorder_tb.sv
`timescale 1ns/1ns

module audio_recorder_tb;
    import rec_ctrl_pkg::*;
    import rec_sample_pkg::*;

    localparam int DEBOUNCE    = 8;
    localparam int STB_GAP     = 5;
    // strobes of all tests in the sequence below
    localparam int ALL_STROBES = 6020;
    localparam int CYCLE_LIMIT = 4 * ALL_STROBES * STB_GAP + 2000;
    localparam int KEY_REC     = 0;
    localparam int KEY_PLAY    = 1;
    localparam int KEY_STOP    = 2;

    logic            clk = 1'b0;
    logic            rst;
    logic [2:0]      key;
    play_cfg_t       cfg;
    logic            stb;
    sample_t         adc;
    sample_t         dac;
    logic            dac_valid;
    logic [5:0]      led;
    logic [7:0][6:0] hex;

    sample_t     ref_mem [MEM_DEPTH];
    sample_t     exp_q [$];
    logic [15:0] lfsr = 16'd29179;
    int          take_len = 0;
    int          mpos = 0;
    int          mphase = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    audio_recorder_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE)
    ) dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_key       (key),
        .i_cfg       (cfg),
        .i_sample_stb(stb),
        .i_adc_sample(adc),
        .o_dac_sample(dac),
        .o_dac_valid (dac_valid),
        .o_led_state (led),
        .o_hex       (hex)
    );

    always #2 clk = ~clk;

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic next_sample(output sample_t v);
        for (int b = 0; b < SAMPLE_W; b++) begin
            v    = {v[SAMPLE_W-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // decodes an active-low digit to its value or -1 if unknown
    function automatic int seg_value(input logic [6:0] seg);
        case (seg)
            7'h40: return 0;
            7'h79: return 1;
            7'h24: return 2;
            7'h30: return 3;
            7'h19: return 4;
            7'h12: return 5;
            7'h02: return 6;
            7'h78: return 7;
            7'h00: return 8;
            7'h10: return 9;
            7'h08: return 10;
            7'h03: return 11;
            7'h46: return 12;
            7'h21: return 13;
            7'h06: return 14;
            7'h0e: return 15;
            default: return -1;
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic press_key(input int idx);
        key[idx] = 1'b0;
        repeat (DEBOUNCE + 6) @(negedge clk);
        key[idx] = 1'b1;
        repeat (DEBOUNCE + 6) @(negedge clk);
    endtask

    task automatic glitch_key(input int idx);
        key[idx] = 1'b0;
        repeat (DEBOUNCE - 1) @(negedge clk);
        key[idx] = 1'b1;
        repeat (DEBOUNCE + 6) @(negedge clk);
    endtask

    task automatic strobe(input sample_t v);
        stb = 1'b1;
        adc = v;
        @(negedge clk);
        stb = 1'b0;
        repeat (STB_GAP - 1) @(negedge clk);
    endtask

    task automatic start_record();
        take_len = 0;
        press_key(KEY_REC);
    endtask

    task automatic record_strobes(input int n);
        sample_t v;
        for (int i = 0; i < n; i++) begin
            next_sample(v);
            if (take_len < MEM_DEPTH) begin
                ref_mem[take_len] = v;
                take_len++;
            end
            strobe(v);
        end
    endtask

    // strobes that must leave no trace
    task automatic drop_strobes(input int n);
        sample_t v;
        for (int i = 0; i < n; i++) begin
            next_sample(v);
            strobe(v);
        end
    endtask

    task automatic start_play();
        mpos   = 0;
        mphase = 0;
        press_key(KEY_PLAY);
    endtask

    // queues the expected output of each strobe before the model position steps on
    task automatic play_strobes(input int n);
        int      grp;
        int      step;
        int      nbr;
        int      cur;
        int      want;
        sample_t v;
        for (int i = 0; i < n; i++) begin
            grp  = (!cfg.fast && cfg.k != 2'd0) ? (1 << cfg.k) : 1;
            step = cfg.fast ? (1 << cfg.k) : 1;
            nbr  = (mpos + 1 < take_len) ? mpos + 1 : mpos;
            cur  = int'(ref_mem[mpos]);
            if (cfg.interp && grp > 1) begin
                want = cur + (((int'(ref_mem[nbr]) - cur) * mphase) >>> cfg.k);
            end else begin
                want = cur;
            end
            exp_q.push_back(sample_t'(want));
            if (mphase == grp - 1) begin
                mphase = 0;
                mpos   = mpos + step;
            end else begin
                mphase++;
            end
            next_sample(v);
            strobe(v);
        end
    endtask

    function automatic int play_length(input int len);
        int step;
        int grp;
        step = cfg.fast ? (1 << cfg.k) : 1;
        grp  = (!cfg.fast && cfg.k != 2'd0) ? (1 << cfg.k) : 1;
        return ((len + step - 1) / step) * grp;
    endfunction

    task automatic check_state(input rec_state_e s);
        checks++;
        assert (led == (6'd1 << s)) else begin
            $display("mismatch at %0t: LEDs %b, expected state %s", $time, led, s.name());
            errors++;
        end
    endtask

    task automatic check_end_addr(input int exp_end);
        int shown;
        shown = 0;
        for (int d = 3; d >= 0; d--) begin
            shown = shown * 16 + seg_value(hex[d]);
        end
        checks++;
        assert (shown == exp_end) else begin
            $display("mismatch at %0t: display shows end address %0d, expected %0d",
                     $time, shown, exp_end);
            errors++;
        end
    endtask

    // speed factor digit and upper play position digits
    task automatic check_play_digits();
        int factor;
        int pos_hi;
        factor = seg_value(hex[6]);
        pos_hi = seg_value(hex[5]) * 16 + seg_value(hex[4]);
        checks++;
        assert ((factor == (1 << cfg.k)) && (pos_hi == (mpos >> 4))) else begin
            $display("mismatch at %0t: speed %0d position %0h, expected %0d and %0h",
                     $time, factor, pos_hi, 1 << cfg.k, mpos >> 4);
            errors++;
        end
    endtask

    task automatic finish_play();
        wait_cycles(4);
        check_state(REC_IDLE);
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("%0d expected DAC samples never came out", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic full_play(input logic fast_on, input logic interp_on, input logic [1:0] k_exp);
        cfg.fast   = fast_on;
        cfg.interp = interp_on;
        cfg.k      = k_exp;
        start_play();
        check_play_digits();
        play_strobes(play_length(take_len));
        finish_play();
    endtask

    // scoreboard checks each DAC sample against the queue
    always @(negedge clk) begin
        sample_t want;
        if (!rst && dac_valid) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("DAC output at %0t while no sample was expected", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                assert (dac == want) else begin
                    $display("mismatch at %0t: DAC sample %0d, expected %0d", $time, dac, want);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        key = 3'b111;
        cfg = '0;
        stb = 1'b0;
        adc = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        wait_cycles(2);

        // first take of 200 samples
        start_record();
        check_state(REC_RECORD);
        record_strobes(200);
        press_key(KEY_STOP);
        check_state(REC_IDLE);
        check_end_addr(200);

        // normal, fast, slow repeat and slow interpolated playback
        full_play(1'b0, 1'b0, 2'd0);
        full_play(1'b1, 1'b0, 2'd2);
        full_play(1'b0, 1'b0, 2'd1);
        full_play(1'b0, 1'b1, 2'd2);

        // record pause drops the strobes
        start_record();
        record_strobes(60);
        press_key(KEY_REC);
        check_state(REC_RECORD_PAUSE);
        drop_strobes(10);
        press_key(KEY_REC);
        check_state(REC_RECORD);
        record_strobes(40);
        press_key(KEY_STOP);
        check_end_addr(100);
        full_play(1'b0, 1'b0, 2'd0);

        // play pause holds the position
        start_play();
        play_strobes(30);
        press_key(KEY_PLAY);
        check_state(REC_PLAY_PAUSE);
        check_play_digits();
        drop_strobes(10);
        press_key(KEY_PLAY);
        check_state(REC_PLAY);
        play_strobes(20);
        press_key(KEY_STOP);
        finish_play();

        glitch_key(KEY_REC);
        check_state(REC_IDLE);
        check_end_addr(100);

        // take longer than the memory
        start_record();
        record_strobes(4100);
        wait_cycles(4);
        check_state(REC_IDLE);
        // end address register tops out at the 12-bit maximum
        check_end_addr(MEM_DEPTH - 1);

        wait_cycles(10);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.asrt0.fail_count);
        if (errors == 0 && dut.asrt0.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
